/* include/lsu_settings.svh */
/*
  Fixed widths and sizes of the load/store unit.
  The design has no module parameters, so every file that needs a
  width includes this header. Values other than these are untested.
  The load_info_s layout in lsu_pkg assumes a 32-bit data word.
*/

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Data path and address
`define LSU_DATA_W 32
`define LSU_ADDR_W 32

// Register file
`define LSU_REG_N    32
`define LSU_REG_ID_W 5

// Load/store immediate, sign extended to the address width
`define LSU_IMM_W 12

// One mask bit per byte of the data word
`define LSU_MASK_W 4

`endif

/* logic/lsu_pkg.sv */
/*
  Types shared by the load/store unit and its testbench.
  The memory payload word is decoded two ways: stores carry the
  replicated store word, loads carry their return information.
  Memory must hand the read_info view back unchanged with the data.
*/

`include "lsu_settings.svh"

package lsu_pkg;

  // Access size, halfword and word accesses are assumed aligned
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

  // Return information of a load, fills exactly one data word
  typedef struct packed {
    logic [`LSU_DATA_W-`LSU_REG_ID_W-6:0] rsvd;
    logic                                 is_unsigned;
    mem_size_e                            size;
    // Low two address bits, picks the byte lane on return
    logic [1:0]                           part_sel;
    logic [`LSU_REG_ID_W-1:0]             reg_id;
  } load_info_s;

  // Payload of a memory request
  typedef union packed {
    logic [`LSU_DATA_W-1:0] write_data;
    load_info_s             read_info;
  } mem_payload_u;

endpackage

/* logic/reg_file.sv */
/*
  Register file, 32 words, two asynchronous reads and one write.
  A read of the register being written returns the new value.
  Register 0 reads zero and writes to it are dropped.
  All registers are cleared by reset.
*/

`timescale 1ns/1ns

`include "lsu_settings.svh"

module reg_file (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     w_v_i,
  input  logic [`LSU_REG_ID_W-1:0] w_addr_i,
  input  logic [`LSU_DATA_W-1:0]   w_data_i,
  input  logic [`LSU_REG_ID_W-1:0] r0_addr_i,
  output logic [`LSU_DATA_W-1:0]   r0_data_o,
  input  logic [`LSU_REG_ID_W-1:0] r1_addr_i,
  output logic [`LSU_DATA_W-1:0]   r1_data_o
);

  logic [`LSU_DATA_W-1:0] regs_r [`LSU_REG_N];

  // One read port, write-through from the port being written this cycle
  function automatic logic [`LSU_DATA_W-1:0] read_port(
    input logic [`LSU_REG_ID_W-1:0] addr,
    input logic [`LSU_DATA_W-1:0]   stored
  );
    if (addr == '0) begin
      return '0;
    end else if (w_v_i && (w_addr_i == addr)) begin
      return w_data_i;
    end
    return stored;
  endfunction

  // Re-evaluated on any write port change as well as on the read address
  always_comb begin
    r0_data_o = read_port(r0_addr_i, regs_r[r0_addr_i]);
    r1_data_o = read_port(r1_addr_i, regs_r[r1_addr_i]);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_r <= '{default: '0};
    end else if (w_v_i && (w_addr_i != '0)) begin
      regs_r[w_addr_i] <= w_data_i;
    end
  end

endmodule

/* logic/load_scoreboard.sv */
/*
  Pending-load scoreboard, one bit per register.
  A bit is set when a load to that register is issued and cleared
  when its response writes back. An operation touching a pending
  register is held off. Register 0 is never scored.
*/

`timescale 1ns/1ns

`include "lsu_settings.svh"

module load_scoreboard (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [`LSU_REG_ID_W-1:0] src1_id_i,
  input  logic [`LSU_REG_ID_W-1:0] src2_id_i,
  input  logic [`LSU_REG_ID_W-1:0] dest_id_i,
  input  logic                     reads_src2_i,
  input  logic                     score_i,
  input  logic                     clear_i,
  input  logic [`LSU_REG_ID_W-1:0] clear_id_i,
  output logic                     dependency_o
);

  logic [`LSU_REG_N-1:0] pending_r;

  // Base register always read, store data only by stores
  // Dest check keeps a second load from racing an older one to the same rd
  assign dependency_o = pending_r[src1_id_i]
                      | pending_r[dest_id_i]
                      | (reads_src2_i & pending_r[src2_id_i]);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r <= '0;
    end else begin
      // Returning load frees its register
      if (clear_i) begin
        pending_r[clear_id_i] <= 1'b0;
      end
      // New load claims its destination, later in the block so it wins
      if (score_i && (dest_id_i != '0)) begin
        pending_r[dest_id_i] <= 1'b1;
      end
    end
  end

endmodule

/* logic/mem_request.sv */
/*
  Memory request register of the load/store unit.
  Address is base plus sign-extended immediate, no alignment check.
  A taken operation shows on mem_v_o the next cycle and is held
  unchanged until mem_yumi_i accepts it. take_i must only be raised
  while slot_free_o is high.
*/

`timescale 1ns/1ns

`include "lsu_settings.svh"

module mem_request (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     take_i,
  input  logic                     store_i,
  input  lsu_pkg::mem_size_e       size_i,
  input  logic                     unsigned_i,
  input  logic [`LSU_REG_ID_W-1:0] rd_i,
  input  logic [`LSU_DATA_W-1:0]   base_i,
  input  logic [`LSU_IMM_W-1:0]    imm_i,
  input  logic [`LSU_DATA_W-1:0]   store_val_i,
  input  logic                     mem_yumi_i,
  output logic                     slot_free_o,
  output logic                     mem_v_o,
  output logic                     mem_w_o,
  output logic [`LSU_ADDR_W-1:0]   mem_addr_o,
  output logic [`LSU_MASK_W-1:0]   mem_mask_o,
  output lsu_pkg::mem_payload_u    mem_payload_o
);

  logic                   v_r;
  logic [`LSU_ADDR_W-1:0] addr_c;
  logic [`LSU_MASK_W-1:0] mask_c;
  logic [`LSU_DATA_W-1:0] store_word_c;
  lsu_pkg::mem_payload_u  payload_c;

  assign addr_c = base_i + {{(`LSU_ADDR_W-`LSU_IMM_W){imm_i[`LSU_IMM_W-1]}}, imm_i};

  // Byte lanes and store data, replicated so memory can take any lane
  always_comb begin
    case (size_i)
      lsu_pkg::SIZE_BYTE: begin
        store_word_c = {(`LSU_DATA_W/8){store_val_i[7:0]}};
        mask_c       = `LSU_MASK_W'(1) << addr_c[1:0];
      end
      lsu_pkg::SIZE_HALF: begin
        store_word_c = {(`LSU_DATA_W/16){store_val_i[15:0]}};
        mask_c       = `LSU_MASK_W'(2'b11) << {addr_c[1], 1'b0};
      end
      default: begin
        store_word_c = store_val_i;
        mask_c       = '1;
      end
    endcase
  end

  // Loads send their return information in place of data
  always_comb begin
    if (store_i) begin
      payload_c.write_data = store_word_c;
    end else begin
      payload_c.read_info = '{rsvd:        '0,
                              is_unsigned: unsigned_i,
                              size:        size_i,
                              part_sel:    addr_c[1:0],
                              reg_id:      rd_i};
    end
  end

  // Free now, or freed by the acceptance at this edge
  assign slot_free_o = ~v_r | mem_yumi_i;
  assign mem_v_o     = v_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (take_i) begin
      v_r <= 1'b1;
    end else if (mem_yumi_i) begin
      v_r <= 1'b0;
    end
  end

  // Request fields only change on a take
  always_ff @(posedge clk_i) begin
    if (take_i) begin
      mem_w_o       <= store_i;
      mem_addr_o    <= addr_c;
      mem_mask_o    <= mask_c;
      mem_payload_o <= payload_c;
    end
  end

endmodule

/* logic/load_writeback.sv */
/*
  Load write-back and register write-port arbiter, combinational.
  The loaded word is packed using the response's own load info,
  so responses may return in any order.
  Load returns have fixed priority over the ALU port, which sees
  alu_ready_o low while a load writes. Writes to register 0 are dropped.
*/

`timescale 1ns/1ns

`include "lsu_settings.svh"

module load_writeback (
  input  logic                     resp_v_i,
  input  logic [`LSU_DATA_W-1:0]   resp_data_i,
  input  lsu_pkg::load_info_s      resp_info_i,
  input  logic                     alu_v_i,
  input  logic [`LSU_REG_ID_W-1:0] alu_rd_i,
  input  logic [`LSU_DATA_W-1:0]   alu_data_i,
  output logic                     alu_ready_o,
  output logic                     w_v_o,
  output logic [`LSU_REG_ID_W-1:0] w_addr_o,
  output logic [`LSU_DATA_W-1:0]   w_data_o
);

  logic [`LSU_DATA_W-1:0] shifted_c;
  logic [`LSU_DATA_W-1:0] load_val_c;
  logic                   sign_c;
  logic                   load_writes_c;

  // Move the addressed lane down to bit 0
  assign shifted_c = resp_data_i >> {resp_info_i.part_sel, 3'b000};

  // Zero or sign extend the selected byte or halfword
  always_comb begin
    case (resp_info_i.size)
      lsu_pkg::SIZE_BYTE: begin
        sign_c     = ~resp_info_i.is_unsigned & shifted_c[7];
        load_val_c = {{(`LSU_DATA_W-8){sign_c}}, shifted_c[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        sign_c     = ~resp_info_i.is_unsigned & shifted_c[15];
        load_val_c = {{(`LSU_DATA_W-16){sign_c}}, shifted_c[15:0]};
      end
      default: begin
        sign_c     = 1'b0;
        load_val_c = resp_data_i;
      end
    endcase
  end

  // A load to register 0 still returns but writes nothing
  assign load_writes_c = resp_v_i & (resp_info_i.reg_id != '0);
  assign alu_ready_o   = ~load_writes_c;

  always_comb begin
    if (load_writes_c) begin
      w_v_o    = 1'b1;
      w_addr_o = resp_info_i.reg_id;
      w_data_o = load_val_c;
    end else begin
      w_v_o    = alu_v_i & (alu_rd_i != '0);
      w_addr_o = alu_rd_i;
      w_data_o = alu_data_i;
    end
  end

endmodule

/* logic/lsu_top.sv */
/*
  Non-blocking load/store unit of the pipelined core.
  Operands are read in the cycle an operation is taken and the
  request leaves one cycle later. Several loads may be in flight;
  anything touching a pending load's register waits for its return.
  Responses are never back-pressured. The ALU port yields to loads.
*/

`timescale 1ns/1ns

`include "lsu_settings.svh"

module lsu_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Operation port
  input  logic                     op_v_i,
  input  logic                     op_store_i,
  input  lsu_pkg::mem_size_e       op_size_i,
  input  logic                     op_unsigned_i,
  input  logic [`LSU_REG_ID_W-1:0] op_rs1_i,
  input  logic [`LSU_REG_ID_W-1:0] op_rs2_i,
  input  logic [`LSU_REG_ID_W-1:0] op_rd_i,
  input  logic [`LSU_IMM_W-1:0]    op_imm_i,
  output logic                     op_ready_o,
  // ALU result write port
  input  logic                     alu_v_i,
  input  logic [`LSU_REG_ID_W-1:0] alu_rd_i,
  input  logic [`LSU_DATA_W-1:0]   alu_data_i,
  output logic                     alu_ready_o,
  // Memory request
  output logic                     mem_v_o,
  output logic                     mem_w_o,
  output logic [`LSU_ADDR_W-1:0]   mem_addr_o,
  output logic [`LSU_MASK_W-1:0]   mem_mask_o,
  output lsu_pkg::mem_payload_u    mem_payload_o,
  input  logic                     mem_yumi_i,
  // Memory response
  input  logic                     resp_v_i,
  input  logic [`LSU_DATA_W-1:0]   resp_data_i,
  input  lsu_pkg::load_info_s      resp_info_i,
  output logic                     resp_yumi_o,
  // Register write observation
  output logic                     rf_w_v_o,
  output logic [`LSU_REG_ID_W-1:0] rf_w_addr_o,
  output logic [`LSU_DATA_W-1:0]   rf_w_data_o
);

  logic [`LSU_DATA_W-1:0] rs1_val;
  logic [`LSU_DATA_W-1:0] rs2_val;
  logic                   dependency;
  logic                   slot_free;
  logic                   take;

  // Ready needs a free request slot and no pending-load hazard
  assign op_ready_o  = slot_free & ~dependency;
  assign take        = op_v_i & op_ready_o;
  assign resp_yumi_o = resp_v_i;

  reg_file rf (
    .clk_i(clk_i), .reset_i(reset_i),
    .w_v_i(rf_w_v_o), .w_addr_i(rf_w_addr_o), .w_data_i(rf_w_data_o),
    .r0_addr_i(op_rs1_i), .r0_data_o(rs1_val),
    .r1_addr_i(op_rs2_i), .r1_data_o(rs2_val)
  );

  // Loads score on take, clear when their response arrives
  load_scoreboard sb (
    .clk_i(clk_i), .reset_i(reset_i),
    .src1_id_i(op_rs1_i), .src2_id_i(op_rs2_i), .dest_id_i(op_rd_i),
    .reads_src2_i(op_store_i),
    .score_i(take & ~op_store_i),
    .clear_i(resp_v_i), .clear_id_i(resp_info_i.reg_id),
    .dependency_o(dependency)
  );

  mem_request req (
    .clk_i(clk_i), .reset_i(reset_i),
    .take_i(take), .store_i(op_store_i), .size_i(op_size_i),
    .unsigned_i(op_unsigned_i), .rd_i(op_rd_i),
    .base_i(rs1_val), .imm_i(op_imm_i), .store_val_i(rs2_val),
    .mem_yumi_i(mem_yumi_i), .slot_free_o(slot_free),
    .mem_v_o(mem_v_o), .mem_w_o(mem_w_o), .mem_addr_o(mem_addr_o),
    .mem_mask_o(mem_mask_o), .mem_payload_o(mem_payload_o)
  );

  // Arbitrated write port feeds the register file and the observation outputs
  load_writeback wb (
    .resp_v_i(resp_v_i), .resp_data_i(resp_data_i), .resp_info_i(resp_info_i),
    .alu_v_i(alu_v_i), .alu_rd_i(alu_rd_i), .alu_data_i(alu_data_i),
    .alu_ready_o(alu_ready_o),
    .w_v_o(rf_w_v_o), .w_addr_o(rf_w_addr_o), .w_data_o(rf_w_data_o)
  );

endmodule

/* tb/tb_clock.sv */
/*
  Testbench clock, 10 ns period.
  Reset is high for the first four rising edges and drops 1 ns after the fourth.
*/

`timescale 1ns/1ns

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Synchronous reset, released just after an edge
  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

/* tb/lsu_top_tb.sv */
/*
  Testbench of the load/store unit, records come from tb/lsu_input.dat.
  Memory is modelled as 256 words indexed by address bits 9:2.
  Load returns are held while another load is offered or waiting,
  which makes back-to-back loads return youngest first.
  Runs stop at the first error and after 40 cycles per record.
*/

`timescale 1ns/1ns

`include "lsu_settings.svh"

module lsu_top_tb;

  localparam int REC_W = 9;
  localparam int REC_MAX = 64;

  logic clk_i, reset_i;
  logic op_v_i, op_store_i, op_unsigned_i, op_ready_o;
  lsu_pkg::mem_size_e op_size_i;
  logic [`LSU_REG_ID_W-1:0] op_rs1_i, op_rs2_i, op_rd_i, alu_rd_i, rf_w_addr_o;
  logic [`LSU_IMM_W-1:0] op_imm_i;
  logic alu_v_i, alu_ready_o, mem_v_o, mem_w_o, mem_yumi_i, resp_v_i, resp_yumi_o, rf_w_v_o;
  logic [`LSU_DATA_W-1:0] alu_data_i, resp_data_i, rf_w_data_o;
  logic [`LSU_ADDR_W-1:0] mem_addr_o;
  logic [`LSU_MASK_W-1:0] mem_mask_o;
  lsu_pkg::mem_payload_u mem_payload_o;
  lsu_pkg::load_info_s resp_info_i;

  logic [31:0] recs [REC_MAX*REC_W];
  logic [31:0] mem [256];
  logic [31:0] lfsr;
  // Register values as the test expects them
  logic [`LSU_DATA_W-1:0] shadow [`LSU_REG_N];
  logic [`LSU_DATA_W-1:0] exp_load [`LSU_REG_N];
  string load_name [`LSU_REG_N];
  int issued_n [`LSU_REG_N];
  int returned_n [`LSU_REG_N];
  int loads_issued, loads_back, cycles, limit, collisions, alu_req_n, alu_ack_n;
  logic [`LSU_REG_ID_W-1:0] alu_rd_q;
  logic [`LSU_DATA_W-1:0] alu_data_q, alu_exp_q;
  logic alu_wait_resp;
  // Sampled at the falling edge for the memory model
  logic acc_v, acc_w, load_waiting, offer_load, alu_acc;
  logic [`LSU_ADDR_W-1:0] acc_addr;
  logic [`LSU_MASK_W-1:0] acc_mask;
  lsu_pkg::mem_payload_u acc_payload;
  // Loads in flight, countdown until return
  int q_cnt [$];
  logic [7:0] q_word [$];
  lsu_pkg::load_info_s q_info [$];

  tb_clock clock_gen (.clk_o(clk_i), .reset_o(reset_i));

  lsu_top DUT (.*);

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic take_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rf_write(input string name, input logic [`LSU_REG_ID_W-1:0] exp_id,
                                input logic [`LSU_DATA_W-1:0] exp_data);
    if (!rf_w_v_o || rf_w_addr_o !== exp_id || rf_w_data_o !== exp_data) begin
      stop_on_error($sformatf("ERROR %s: expected write r%0d = %h, actual v=%b r%0d = %h",
                              name, exp_id, exp_data, rf_w_v_o, rf_w_addr_o, rf_w_data_o));
    end
  endtask

  task automatic check_mem_req(input string name, input logic exp_w,
                               input lsu_pkg::mem_payload_u exp_pl,
                               input logic [`LSU_MASK_W-1:0] exp_mask,
                               input logic [`LSU_ADDR_W-1:0] exp_addr);
    if (mem_w_o !== exp_w || mem_payload_o !== exp_pl || mem_mask_o !== exp_mask
        || mem_addr_o !== exp_addr) begin
      stop_on_error($sformatf("ERROR %s: expected req w=%b %h/%h @%h, actual w=%b %h/%h @%h",
                              name, exp_w, exp_pl, exp_mask, exp_addr,
                              mem_w_o, mem_payload_o, mem_mask_o, mem_addr_o));
    end
  endtask

  task automatic check_mem_word(input string name, input logic [7:0] idx,
                                input logic [`LSU_DATA_W-1:0] exp_word);
    if (mem[idx] !== exp_word) begin
      stop_on_error($sformatf("ERROR %s: expected memory word %h, actual %h",
                              name, exp_word, mem[idx]));
    end
  endtask

  // ALU write, optionally started together with a load response
  task automatic do_alu(input string name, input logic [`LSU_REG_ID_W-1:0] rd,
                        input logic [`LSU_DATA_W-1:0] data, input logic [`LSU_DATA_W-1:0] exp,
                        input logic collide);
    int coll_start;
    coll_start = collisions;
    alu_rd_q = rd;
    alu_data_q = data;
    alu_exp_q = exp;
    alu_wait_resp = collide;
    alu_req_n++;
    while (alu_req_n != alu_ack_n) @(negedge clk_i);
    if (collide && collisions == coll_start) begin
      stop_on_error($sformatf("%s: the ALU write was never held off by a load response", name));
    end
  endtask

  task automatic do_op(input string name, input logic store, input lsu_pkg::mem_size_e size,
                       input logic uns, input logic [`LSU_REG_ID_W-1:0] rs1,
                       input logic [`LSU_REG_ID_W-1:0] rs2, input logic [`LSU_REG_ID_W-1:0] rd,
                       input logic [`LSU_IMM_W-1:0] imm, input logic [`LSU_DATA_W-1:0] exp);
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_MASK_W-1:0] mask;
    logic [`LSU_DATA_W-1:0] sval;
    lsu_pkg::mem_payload_u pl;
    @(posedge clk_i);
    #1;
    op_v_i = 1'b1;
    op_store_i = store;
    op_size_i = size;
    op_unsigned_i = uns;
    op_rs1_i = rs1;
    op_rs2_i = rs2;
    op_rd_i = rd;
    op_imm_i = imm;
    @(negedge clk_i);
    while (!op_ready_o) @(negedge clk_i);
    // Nothing touching a register of a load in flight may be taken
    if (issued_n[rs1] != returned_n[rs1] || (store && issued_n[rs2] != returned_n[rs2])
        || (!store && issued_n[rd] != returned_n[rd])) begin
      stop_on_error($sformatf("%s: taken while a load to one of its registers was in flight",
                              name));
    end
    addr = shadow[rs1] + {{(`LSU_ADDR_W-`LSU_IMM_W){imm[`LSU_IMM_W-1]}}, imm};
    sval = shadow[rs2];
    if (size == lsu_pkg::SIZE_BYTE) begin
      mask = 4'b0001 << addr[1:0];
      sval = {4{sval[7:0]}};
    end else if (size == lsu_pkg::SIZE_HALF) begin
      mask = addr[1] ? 4'b1100 : 4'b0011;
      sval = {2{sval[15:0]}};
    end else begin
      mask = 4'b1111;
    end
    if (store) begin
      pl.write_data = sval;
    end else begin
      pl.read_info = '{rsvd: '0, is_unsigned: uns, size: size, part_sel: addr[1:0], reg_id: rd};
      exp_load[rd] = exp;
      load_name[rd] = name;
      issued_n[rd] += (rd != '0) ? 1 : 0;
      loads_issued++;
    end
    @(posedge clk_i);
    #1;
    op_v_i = 1'b0;
    // Request is held until memory takes it
    @(negedge clk_i);
    while (!(mem_v_o && mem_yumi_i)) @(negedge clk_i);
    check_mem_req(name, store, pl, mask, addr);
    if (store) begin
      @(negedge clk_i);
      check_mem_word(name, addr[9:2], exp);
    end
  endtask

  // Falling edge monitor, checks register writes and samples for the memory model
  always @(negedge clk_i) begin
    if (!reset_i) begin
      cycles++;
      if (cycles >= limit) begin
        stop_on_error($sformatf("Timeout: the run did not finish within %0d cycles", limit));
      end
      // Responses are taken in the cycle they arrive
      if (resp_yumi_o !== resp_v_i) begin
        stop_on_error($sformatf("ERROR response accept: expected resp_yumi_o %b, actual %b",
                                resp_v_i, resp_yumi_o));
      end
      acc_v = mem_v_o && mem_yumi_i;
      acc_w = mem_w_o;
      acc_addr = mem_addr_o;
      acc_mask = mem_mask_o;
      acc_payload = mem_payload_o;
      load_waiting = mem_v_o && !mem_w_o && !mem_yumi_i;
      offer_load = op_v_i && !op_store_i && op_ready_o;
      alu_acc = alu_v_i && alu_ready_o;
      if (resp_v_i) begin
        loads_back++;
        if (resp_info_i.reg_id != '0) begin
          check_rf_write(load_name[resp_info_i.reg_id], resp_info_i.reg_id,
                         exp_load[resp_info_i.reg_id]);
          shadow[resp_info_i.reg_id] = exp_load[resp_info_i.reg_id];
          returned_n[resp_info_i.reg_id]++;
        end
      end
      if (alu_v_i && !alu_ready_o) begin
        collisions++;
      end else if (alu_v_i && alu_rd_q != '0) begin
        check_rf_write("ALU write", alu_rd_q, alu_exp_q);
        shadow[alu_rd_q] = alu_exp_q;
      end else if (alu_v_i && rf_w_v_o) begin
        stop_on_error("An ALU write to register 0 reached the register file");
      end
    end
  end

  // Memory model and ALU port driver, acting 1 ns after each rising edge
  initial begin
    int pick;
    int d;
    logic b1;
    logic b0;
    logic in_reset;
    lfsr = 32'h7701d893;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {4{i[7:0]}} ^ 32'ha5c30f96;
    end
    mem_yumi_i = 1'b0;
    resp_v_i = 1'b0;
    resp_data_i = '0;
    resp_info_i = '0;
    alu_v_i = 1'b0;
    alu_rd_i = '0;
    alu_data_i = '0;
    forever begin
      @(posedge clk_i);
      // Reset as the DUT saw it at this edge
      in_reset = reset_i;
      #1;
      if (!in_reset) begin
        for (int k = 0; k < q_cnt.size(); k++) begin
          if (q_cnt[k] > 0) q_cnt[k]--;
        end
        if (acc_v && acc_w) begin
          for (int k = 0; k < 4; k++) begin
            if (acc_mask[k]) mem[acc_addr[9:2]][8*k +: 8] = acc_payload.write_data[8*k +: 8];
          end
        end else if (acc_v) begin
          b1 = take_bit();
          b0 = take_bit();
          d = 1 + 2 * int'(b1) + int'(b0);
          // Older loads wait for the new one
          for (int k = 0; k < q_cnt.size(); k++) begin
            if (q_cnt[k] <= d) q_cnt[k] = d + 1;
          end
          q_cnt.push_back(d);
          q_word.push_back(acc_addr[9:2]);
          q_info.push_back(acc_payload.read_info);
        end
        pick = -1;
        for (int k = 0; k < q_cnt.size(); k++) begin
          if (pick < 0 && q_cnt[k] == 0 && !load_waiting && !offer_load) pick = k;
        end
        resp_v_i = (pick >= 0);
        if (pick >= 0) begin
          resp_info_i = q_info[pick];
          resp_data_i = mem[q_word[pick]];
          q_cnt.delete(pick);
          q_word.delete(pick);
          q_info.delete(pick);
        end
        if (alu_v_i && alu_acc) begin
          alu_v_i = 1'b0;
          alu_ack_n++;
        end else if (!alu_v_i && alu_req_n != alu_ack_n && (!alu_wait_resp || resp_v_i)) begin
          alu_v_i = 1'b1;
          alu_rd_i = alu_rd_q;
          alu_data_i = alu_data_q;
        end
        mem_yumi_i = take_bit();
      end
    end
  end

  initial begin
    int n_rec;
    int b;
    string name;
    op_v_i = 1'b0;
    op_store_i = 1'b0;
    op_size_i = lsu_pkg::SIZE_WORD;
    op_unsigned_i = 1'b0;
    op_rs1_i = '0;
    op_rs2_i = '0;
    op_rd_i = '0;
    op_imm_i = '0;
    limit = 1000000;
    for (int i = 0; i < `LSU_REG_N; i++) begin
      shadow[i] = '0;
      issued_n[i] = 0;
      returned_n[i] = 0;
    end
    $readmemh("tb/lsu_input.dat", recs);
    n_rec = 0;
    while (n_rec < REC_MAX && recs[n_rec*REC_W] != 32'hf) n_rec++;
    limit = 40 * n_rec;
    wait (!reset_i);
    for (int r = 0; r < n_rec; r++) begin
      b = r * REC_W;
      name = $sformatf("record %0d", r);
      if (recs[b] == 32'd0 || recs[b] == 32'd3) begin
        do_alu(name, recs[b+5][4:0], recs[b+7], recs[b+8], recs[b] == 32'd3);
      end else begin
        do_op(name, recs[b] == 32'd2, lsu_pkg::mem_size_e'(recs[b+1][1:0]), recs[b+2][0],
              recs[b+3][4:0], recs[b+4][4:0], recs[b+5][4:0], recs[b+6][11:0], recs[b+8]);
      end
    end
    while (loads_back != loads_issued || alu_req_n != alu_ack_n) @(negedge clk_i);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* lsu_top.f */
+incdir+include
logic/lsu_pkg.sv
logic/reg_file.sv
logic/load_scoreboard.sv
logic/mem_request.sv
logic/load_writeback.sv
logic/lsu_top.sv
tb/tb_clock.sv
tb/lsu_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= lsu_top_tb
FILELIST  ?= lsu_top.f
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "\*\*\* TEST PASSED \*\*\*"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tb/lsu_input.dat */
// kind size uns rs1 rs2 rd imm data expected, kind 0 ALU 1 load 2 store 3 ALU on a load return
// size 0 byte 1 half 2 word, expected is the written register or the memory word after a store
0 0 0 00 00 01 000 00000100 00000100
0 0 0 00 00 02 000 11223344 11223344
0 0 0 00 00 00 000 deadbeef 00000000
0 0 0 00 00 03 000 cafef00d cafef00d
// Stores of each size, a negative offset and the zero register as data
2 2 0 01 02 00 000 00000000 11223344
2 0 0 01 03 00 001 00000000 11220d44
2 1 0 01 03 00 002 00000000 f00d0d44
2 2 0 01 00 00 004 00000000 00000000
2 2 0 01 02 00 ffc 00000000 11223344
2 2 0 01 03 00 008 00000000 cafef00d
// Loads of each size and signedness
1 0 0 01 00 04 003 00000000 fffffff0
1 0 1 01 00 05 003 00000000 000000f0
1 1 0 01 00 06 002 00000000 fffff00d
1 1 1 01 00 07 000 00000000 00000d44
1 2 0 01 00 08 008 00000000 cafef00d
// Store data and store base waiting on loads
1 2 0 01 00 09 000 00000000 f00d0d44
2 2 0 01 09 00 00c 00000000 f00d0d44
2 2 0 01 01 00 010 00000000 00000100
1 2 0 01 00 0b 010 00000000 00000100
2 2 0 0b 03 00 014 00000000 cafef00d
// Two loads in flight
1 2 0 01 00 0c 008 00000000 cafef00d
1 1 1 01 00 0d ffc 00000000 00003344
// ALU write meeting a load return, then both registers stored
1 2 0 01 00 0e 004 00000000 00000000
3 0 0 00 00 0f 000 0f0f0f0f 0f0f0f0f
2 2 0 01 0f 00 018 00000000 0f0f0f0f
2 2 0 01 0e 00 01c 00000000 00000000
// End of list
f 0 0 00 00 00 000 00000000 00000000
